/* flist.f */
source/fetch_pkg.sv
source/addr_translate.sv
source/fetch_ctrl.sv
source/inflight_counter.sv
source/fetch_queue.sv
source/fetch_unit.sv
test/inst_mem_model.sv
test/fetch_tb.sv

/* source/addr_translate.sv */
`timescale 1ns/10ps

module addr_translate import fetch_pkg::*; (
    input  logic [31:0] va,

    input  logic        crmd_pg,
    input  logic [1:0]  crmd_plv,

    input  logic        dmw0_plv_met,
    input  logic [2:0]  dmw0_vseg,
    input  logic [2:0]  dmw0_pseg,
    input  logic        dmw1_plv_met,
    input  logic [2:0]  dmw1_vseg,
    input  logic [2:0]  dmw1_pseg,

    input  logic        s0_found,
    input  logic [19:0] s0_ppn,
    input  logic [5:0]  s0_ps,
    input  logic        s0_v,
    input  logic [1:0]  s0_plv,

    output logic [31:0] pa,
    output logic        exc,
    output logic [5:0]  ecode
);

    logic        hit0;
    logic        hit1;
    logic        tlb_path;   // mapped and no window took it
    logic [31:0] pa_tlb;

    logic        adef;
    logic        tlbr;
    logic        pif;
    logic        ppi;

    // direct map windows compare the top three va bits
    assign hit0 = dmw0_plv_met & (dmw0_vseg == va[31:29]);
    assign hit1 = dmw1_plv_met & (dmw1_vseg == va[31:29]);

    assign tlb_path = crmd_pg & ~hit0 & ~hit1;

    // 4 MB page keeps 21 offset bits, otherwise 12
    assign pa_tlb = (s0_ps == PS_4MB) ? {s0_ppn[19:9], va[20:0]}
                                      : {s0_ppn, va[11:0]};

    always_comb begin
        if (!crmd_pg)
            pa = va;                          // direct address mode
        else if (hit0)
            pa = {dmw0_pseg, va[28:0]};       // window 0 has priority
        else if (hit1)
            pa = {dmw1_pseg, va[28:0]};
        else
            pa = pa_tlb;
    end

    assign adef = |va[1:0];
    assign tlbr = tlb_path & ~s0_found;
    assign pif  = tlb_path & s0_found & ~s0_v;
    assign ppi  = tlb_path & s0_found & s0_v & (crmd_plv > s0_plv);

    assign exc = adef | tlbr | pif | ppi;

    always_comb begin
        if (adef)
            ecode = ECODE_ADEF;
        else if (tlbr)
            ecode = ECODE_TLBR;
        else if (pif)
            ecode = ECODE_PIF;
        else if (ppi)
            ecode = ECODE_PPI;
        else
            ecode = 6'd0;
    end

endmodule

/* source/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    // redirect sources
    input  logic        flush,
    input  logic [31:0] flush_entry,
    input  logic        br_taken,
    input  logic [31:0] br_target,

    input  logic        exc,             // current va faults
    input  logic        tag_full,
    input  logic        inflight_full,
    input  logic        inst_sram_addr_ok,

    output logic [31:0] va,
    output logic        inst_sram_req,
    output logic        tag_push,
    output fetch_tag_t  tag_data,
    output logic        redirect
);

    typedef enum logic [1:0] {
        START,
        FETCH,
        HALTED
    } state_t;

    state_t      state;
    logic [31:0] pc;

    logic        slot_ok;    // room for one more slot this cycle
    logic        accept;
    logic        exc_slot;   // exception slot queued instead of a request

    assign redirect = flush | br_taken;

    assign slot_ok  = (state == FETCH) & ~tag_full & ~inflight_full;
    assign inst_sram_req = slot_ok & ~exc;
    assign accept   = inst_sram_req & inst_sram_addr_ok;
    assign exc_slot = slot_ok & exc;

    // exception slots skip the memory and go straight to the tag queue
    assign tag_push = accept | exc_slot;

    // ecode is filled in by the top from the translator
    assign tag_data = '{pc: pc, excep: exc, ecode: 6'd0};

    assign va = pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= START;
            pc    <= RESET_PC;
        end else if (redirect) begin
            state <= FETCH;
            pc    <= flush ? flush_entry : br_target;   // flush beats branch
        end else begin
            case (state)
                START: begin
                    state <= FETCH;                     // one idle cycle after reset
                end
                FETCH: begin
                    if (accept)
                        pc <= pc + 32'd4;
                    else if (exc_slot)
                        state <= HALTED;                // wait for a redirect
                end
                HALTED: begin
                    state <= HALTED;
                end
                default: begin
                    state <= START;
                end
            endcase
        end
    end

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    // first fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // requests in flight and depth of each queue
    localparam int FETCH_DEPTH = 4;

    // counts run 0..FETCH_DEPTH
    localparam int CNT_W = 3;

    // queue read/write pointer width
    localparam int QPTR_W = $clog2(FETCH_DEPTH);

    // fetch exception codes
    localparam logic [5:0] ECODE_ADEF = 6'h08;  // address error on fetch
    localparam logic [5:0] ECODE_TLBR = 6'h3f;  // tlb refill
    localparam logic [5:0] ECODE_PIF  = 6'h03;  // page invalid on fetch
    localparam logic [5:0] ECODE_PPI  = 6'h07;  // page privilege

    // tlb page size field for a 4 MB page
    // anything else is treated as 4 KB
    localparam logic [5:0] PS_4MB = 6'd21;

    // one fetch slot as it travels toward decode
    typedef struct packed {
        logic [31:0] pc;      // virtual fetch address, also badv on exception
        logic        excep;   // slot carries an exception, no memory request
        logic [5:0]  ecode;
    } fetch_tag_t;

    // raw instruction word from memory
    typedef logic [31:0] inst_t;

endpackage

/* source/fetch_queue.sv */
`timescale 1ns/10ps

module fetch_queue import fetch_pkg::*; #(
    parameter type payload_t = inst_t
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     clear,       // drop all entries
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    payload_t          mem [FETCH_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;

    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FETCH_DEPTH));

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign dout = mem[rd_ptr];   // head is always visible

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!resetn || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    // instruction memory
    output logic        inst_sram_req,
    output logic [31:0] inst_sram_addr,
    input  logic        inst_sram_addr_ok,
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata,

    // decode
    output logic        if_to_id_valid,
    output logic [31:0] if_pc,
    output logic [31:0] if_inst,
    output logic        if_excep,
    output logic [5:0]  if_ecode,
    input  logic        id_allowin,

    // redirects
    input  logic        flush,
    input  logic [31:0] flush_entry,
    input  logic        br_taken,
    input  logic [31:0] br_target,

    // csr state for translation
    input  logic        crmd_pg,
    input  logic [1:0]  crmd_plv,
    input  logic        dmw0_plv_met,
    input  logic [2:0]  dmw0_vseg,
    input  logic [2:0]  dmw0_pseg,
    input  logic        dmw1_plv_met,
    input  logic [2:0]  dmw1_vseg,
    input  logic [2:0]  dmw1_pseg,

    // tlb lookup port
    output logic [18:0] s0_vppn,
    output logic        s0_va_bit12,
    input  logic        s0_found,
    input  logic [19:0] s0_ppn,
    input  logic [5:0]  s0_ps,
    input  logic        s0_v,
    input  logic [1:0]  s0_plv
);

    logic [31:0] va;
    logic        tr_exc;
    logic [5:0]  tr_ecode;

    logic        redirect;
    logic        inflight_full;
    logic        drop;
    logic        issue;

    logic        tag_push;
    fetch_tag_t  tag_data;
    fetch_tag_t  tag_din;
    fetch_tag_t  head_tag;
    logic        tag_empty;
    logic        tag_full;

    inst_t       head_inst;
    logic        inst_empty;
    logic        inst_push;
    logic        xfer;

    assign {s0_vppn, s0_va_bit12} = va[31:12];   // tlb looks up the live pc

    assign issue     = inst_sram_req & inst_sram_addr_ok;
    assign inst_push = inst_sram_data_ok & ~drop;

    // exception code joins the tag here
    always_comb begin
        tag_din       = tag_data;
        tag_din.ecode = tag_data.excep ? tr_ecode : 6'd0;
    end

    // exception slots need no instruction behind them
    assign if_to_id_valid = ~tag_empty & (head_tag.excep | ~inst_empty);
    assign xfer           = if_to_id_valid & id_allowin;

    assign if_pc    = head_tag.pc;
    assign if_excep = head_tag.excep;
    assign if_ecode = head_tag.ecode;
    assign if_inst  = head_tag.excep ? 32'd0 : head_inst;

    fetch_ctrl u_fetch_ctrl (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .flush_entry       (flush_entry),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .exc               (tr_exc),
        .tag_full          (tag_full),
        .inflight_full     (inflight_full),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .va                (va),
        .inst_sram_req     (inst_sram_req),
        .tag_push          (tag_push),
        .tag_data          (tag_data),
        .redirect          (redirect)
    );

    addr_translate u_addr_translate (
        .va           (va),
        .crmd_pg      (crmd_pg),
        .crmd_plv     (crmd_plv),
        .dmw0_plv_met (dmw0_plv_met),
        .dmw0_vseg    (dmw0_vseg),
        .dmw0_pseg    (dmw0_pseg),
        .dmw1_plv_met (dmw1_plv_met),
        .dmw1_vseg    (dmw1_vseg),
        .dmw1_pseg    (dmw1_pseg),
        .s0_found     (s0_found),
        .s0_ppn       (s0_ppn),
        .s0_ps        (s0_ps),
        .s0_v         (s0_v),
        .s0_plv       (s0_plv),
        .pa           (inst_sram_addr),
        .exc          (tr_exc),
        .ecode        (tr_ecode)
    );

    inflight_counter u_inflight_counter (
        .clk           (clk),
        .resetn        (resetn),
        .issue         (issue),
        .data_ok       (inst_sram_data_ok),
        .redirect      (redirect),
        .inflight_full (inflight_full),
        .drop          (drop)
    );

    fetch_queue #(.payload_t(fetch_tag_t)) u_tag_q (
        .clk    (clk),
        .resetn (resetn),
        .clear  (redirect),
        .push   (tag_push),
        .din    (tag_din),
        .pop    (xfer),
        .dout   (head_tag),
        .empty  (tag_empty),
        .full   (tag_full)
    );

    // never overflows, every instruction has its tag queued already
    fetch_queue #(.payload_t(inst_t)) u_inst_q (
        .clk    (clk),
        .resetn (resetn),
        .clear  (redirect),
        .push   (inst_push),
        .din    (inst_sram_rdata),
        .pop    (xfer & ~head_tag.excep),
        .dout   (head_inst),
        .empty  (inst_empty),
        .full   ()
    );

endmodule

/* source/inflight_counter.sv */
`timescale 1ns/10ps

module inflight_counter import fetch_pkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic issue,          // request accepted this cycle
    input  logic data_ok,        // one response returns
    input  logic redirect,
    output logic inflight_full,
    output logic drop            // current response is stale
);

    logic [CNT_W-1:0] inflight_cnt;
    logic [CNT_W-1:0] inflight_nxt;
    logic [CNT_W-1:0] discard_cnt;

    // a response in the redirect cycle is already gone, an issue still counts
    assign inflight_nxt = inflight_cnt + CNT_W'(issue) - CNT_W'(data_ok);

    assign inflight_full = (inflight_cnt == CNT_W'(FETCH_DEPTH));
    assign drop          = |discard_cnt;

    always_ff @(posedge clk) begin
        if (!resetn)
            inflight_cnt <= '0;
        else
            inflight_cnt <= inflight_nxt;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            discard_cnt <= '0;
        else if (redirect)
            discard_cnt <= inflight_nxt;        // everything still out is stale
        else if (data_ok && drop)
            discard_cnt <= discard_cnt - 1'b1;
    end

endmodule

/* test/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam int MAX_CYCLES = 4000;   // about ten times a clean run

    logic        clk = 1'b0;
    logic        resetn = 1'b0;
    logic        flush = 1'b0;
    logic        br_taken = 1'b0;
    logic [31:0] flush_entry = '0;
    logic [31:0] br_target = '0;
    logic        crmd_pg = 1'b0;
    logic [1:0]  crmd_plv = 2'd0;
    logic        dmw0_plv_met = 1'b1;
    logic [2:0]  dmw0_vseg = 3'b101;
    logic [2:0]  dmw0_pseg = 3'b000;
    logic        dmw1_plv_met = 1'b1;
    logic [2:0]  dmw1_vseg = 3'b110;
    logic [2:0]  dmw1_pseg = 3'b001;
    logic        allow_draw = 1'b1;
    logic        rand_allow = 1'b0;
    logic        id_allowin;

    logic [18:0] s0_vppn;
    logic        s0_va_bit12;
    logic        s0_found;
    logic [19:0] s0_ppn;
    logic [5:0]  s0_ps;
    logic        s0_v;
    logic [1:0]  s0_plv;

    logic        inst_sram_req;
    logic [31:0] inst_sram_addr;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic        if_to_id_valid;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic        if_excep;
    logic [5:0]  if_ecode;

    int          seed = 31;
    int          cyc_cnt = 0;
    int          slot_cnt = 0;
    int          since_reset = 0;     // cycles since resetn rose
    logic [31:0] exp_pc = RESET_PC;   // next pc decode should see
    logic [31:0] req_pc = RESET_PC;   // next va the fetch should request
    logic        halted = 1'b0;       // exception slot delivered, no redirect yet
    logic        next_pg = 1'b0;
    logic [1:0]  next_plv = 2'd0;

    // tlb entry derived from the looked up page number
    assign s0_found = ~s0_vppn[18];
    assign s0_v     = ~s0_vppn[17];
    assign s0_ppn   = {s0_vppn, s0_va_bit12} ^ 20'h00055;
    assign s0_ps    = s0_vppn[16] ? PS_4MB : 6'd12;
    assign s0_plv   = 2'd0;

    assign id_allowin = allow_draw & ~flush & ~br_taken;   // no transfer in a redirect cycle

    always #50 clk = ~clk;

    fetch_unit u_fetch_unit (.*);

    inst_mem_model u_inst_mem (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    function automatic logic window_hit(input logic [31:0] va);
        return (dmw0_plv_met && dmw0_vseg == va[31:29]) ||
               (dmw1_plv_met && dmw1_vseg == va[31:29]);
    endfunction

    function automatic logic [31:0] expect_pa(input logic [31:0] va);
        logic [19:0] ppn;
        ppn = va[31:12] ^ 20'h00055;
        if (!crmd_pg)
            return va;
        else if (dmw0_plv_met && dmw0_vseg == va[31:29])
            return {dmw0_pseg, va[28:0]};
        else if (dmw1_plv_met && dmw1_vseg == va[31:29])
            return {dmw1_pseg, va[28:0]};
        else if (va[29])
            return {ppn[19:9], va[20:0]};   // 4 MB page
        return {ppn, va[11:0]};
    endfunction

    // zero when the fetch is clean
    function automatic logic [5:0] expect_ecode(input logic [31:0] va);
        if (va[1:0] != 2'b00)
            return ECODE_ADEF;
        if (!crmd_pg || window_hit(va))
            return 6'd0;
        if (va[31])
            return ECODE_TLBR;
        if (va[30])
            return ECODE_PIF;
        if (crmd_plv > 2'd0)
            return ECODE_PPI;
        return 6'd0;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_slot();
        logic [5:0] code;
        code = expect_ecode(exp_pc);
        check_value("if_pc", if_pc, exp_pc);
        check_value("if_excep", if_excep, code != 6'd0);
        if (code != 6'd0) begin
            check_value("if_ecode", if_ecode, code);
            check_value("if_inst", if_inst, 32'd0);
            halted = 1'b1;
        end else begin
            check_value("if_inst", if_inst, expect_pa(exp_pc) ^ 32'ha5a5a5a5);
            exp_pc = exp_pc + 32'd4;
        end
        slot_cnt++;
    endtask

    // sample mid cycle, everything is settled
    always @(negedge clk) begin : monitor
        if (!resetn)
            since_reset = 0;
        else
            since_reset++;
        if (since_reset <= 1) begin
            assert (!inst_sram_req && !if_to_id_valid)
            else report_fail("request or slot raised during or right after reset");
        end
        if (since_reset == 2)
            check_value("inst_sram_req", inst_sram_req, 1'b1);   // first fetch starts here
        if (resetn) begin
            if (inst_sram_req) begin
                assert (expect_ecode(req_pc) == 6'd0)
                else report_fail("memory request raised for a faulting address");
                check_value("inst_sram_addr", inst_sram_addr, expect_pa(req_pc));
                check_value("s0_vppn", s0_vppn, req_pc[31:13]);
                check_value("s0_va_bit12", s0_va_bit12, req_pc[12]);
                if (inst_sram_addr_ok)
                    req_pc = req_pc + 32'd4;
            end
            assert (!(halted && if_to_id_valid))
            else report_fail("slot offered to decode after an exception without a redirect");
            if (if_to_id_valid && id_allowin)
                check_slot();
            if (flush || br_taken) begin
                exp_pc = flush ? flush_entry : br_target;   // flush has priority
                req_pc = exp_pc;
                halted = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        allow_draw <= rand_allow ? (({$random(seed)} % 4) != 0) : 1'b1;
        if (cyc_cnt >= MAX_CYCLES)
            report_fail($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end

    // one cycle pulse, csr state changes along with it
    task automatic redirect_to(input logic do_flush, input logic do_br,
                               input logic [31:0] f_pc, input logic [31:0] b_pc);
        @(posedge clk);
        flush       <= do_flush;
        br_taken    <= do_br;
        flush_entry <= f_pc;
        br_target   <= b_pc;
        crmd_pg     <= next_pg;
        crmd_plv    <= next_plv;
        @(posedge clk);
        flush    <= 1'b0;
        br_taken <= 1'b0;
    endtask

    task automatic wait_slots(input int n);
        int goal;
        goal = slot_cnt + n;
        while (slot_cnt < goal)
            @(posedge clk);
    endtask

    task automatic wait_halt();
        while (!halted)
            @(posedge clk);
        repeat (10) @(posedge clk);   // fetch must stay quiet
    endtask

    initial begin
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        wait_slots(12);
        rand_allow <= 1'b1;   // decode starts stalling
        wait_slots(20);
        redirect_to(1'b0, 1'b1, 32'h0, 32'h1c00_1000);
        wait_slots(8);
        redirect_to(1'b1, 1'b1, 32'h1c00_2000, 32'h1c00_3000);
        wait_slots(8);
        next_pg = 1'b1;
        redirect_to(1'b1, 1'b0, 32'ha000_1000, 32'h0);   // window 0
        wait_slots(8);
        redirect_to(1'b0, 1'b1, 32'h0, 32'hc000_2000);   // window 1
        wait_slots(8);
        redirect_to(1'b0, 1'b1, 32'h0, 32'h2040_0ff0);   // 4 MB page
        wait_slots(8);
        redirect_to(1'b0, 1'b1, 32'h0, 32'h0001_2ff0);   // 4 KB pages, crosses one
        wait_slots(8);
        redirect_to(1'b0, 1'b1, 32'h0, 32'ha000_0106);   // misaligned
        wait_halt();
        redirect_to(1'b0, 1'b1, 32'h0, 32'h8000_1000);   // tlb miss
        wait_halt();
        redirect_to(1'b0, 1'b1, 32'h0, 32'h4000_1000);   // invalid entry
        wait_halt();
        next_plv = 2'd3;
        redirect_to(1'b0, 1'b1, 32'h0, 32'h0000_1000);   // privilege
        wait_halt();
        next_pg  = 1'b0;
        next_plv = 2'd0;
        redirect_to(1'b1, 1'b0, RESET_PC, 32'h0);
        wait_slots(6);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* test/inst_mem_model.sv */
`timescale 1ns/10ps

module inst_mem_model (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    logic [31:0] rdata_q [$];   // responses waiting, oldest first
    int          due_q [$];     // cycle in which each response goes out
    int          cyc;
    int          last_due;
    int          due;
    int          seed = 31;

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            rdata_q.delete();
            due_q.delete();
            cyc      = 0;
            last_due = 0;
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            if (req && addr_ok) begin
                due = cyc + 1 + ({$random(seed)} % 3);   // 1 to 3 cycles later
                if (due <= last_due)
                    due = last_due + 1;                   // keep responses in order
                last_due = due;
                rdata_q.push_back(addr ^ 32'ha5a5a5a5);
                due_q.push_back(due);
            end
            cyc = cyc + 1;   // now the cycle that starts at this edge
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                data_ok <= 1'b1;
                rdata   <= rdata_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                data_ok <= 1'b0;
            end
            addr_ok <= (({$random(seed)} % 3) != 0);     // stall about a third of the time
        end
    end

endmodule
